// ==== common/icache_pkg.sv ====
package icache_pkg;

    // fixed geometry, PLRU encoding and burst length depend on it
    localparam int LINE_WORDS  = 4;
    localparam int NUM_WAYS    = 4;
    localparam int OFFSET_BITS = $clog2(LINE_WORDS * 4);

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  way_t;
    typedef logic [2:0]  plru_t;       // tree bits, [2] root
    typedef logic [1:0]  beat_len_t;   // beats minus one
    typedef logic [1:0]  word_sel_t;   // word within a line

    localparam beat_len_t LEN_TWO  = 2'd1;
    localparam beat_len_t LEN_FOUR = 2'd3;

    typedef enum logic [1:0] {
        pd_normal,
        pd_branch,
        pd_call,
        pd_ret
    } predecode_t;

    // data stage control
    typedef enum logic [2:0] {
        st_idle,       // waiting for a lookup
        st_lookup,     // hit, array read data valid
        st_refill,     // four-beat line burst
        st_uncached,   // two-beat burst, no allocation
        st_respond     // answer from line buffer
    } line_state_t;

endpackage

// ==== common/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if import icache_pkg::*; ();

    logic      valid;   // held until last beat
    addr_t     addr;
    beat_len_t len;
    logic      ready;   // one beat per ready cycle
    word_t     data;
    logic      last;

    modport master (
        output valid, addr, len,
        input  ready, data, last
    );

    modport slave (
        input  valid, addr, len,
        output ready, data, last
    );

endinterface

// ==== common/lookup_if.sv ====
`timescale 1ns/1ps

interface lookup_if import icache_pkg::*; #(
    parameter int NUM_SETS = 16
) ();

    localparam int IDX_BITS = $clog2(NUM_SETS);

    logic  valid;      // held until done
    addr_t addr;
    logic  uncached;
    logic  hit;
    way_t  way;        // hit way or victim
    logic  done;       // pulses with the response

    logic [IDX_BITS-1:0] index;

    assign index = addr[OFFSET_BITS +: IDX_BITS];

    modport producer (
        output valid, addr, uncached, hit, way,
        input  done, index
    );

    modport consumer (
        input  valid, addr, uncached, hit, way, index,
        output done
    );

endinterface

// ==== verilog/icache/fetch_predecode.sv ====
`timescale 1ns/1ps

module fetch_predecode import icache_pkg::*; (
    input  word_t      instr0,
    input  word_t      instr1,
    output predecode_t pd0,
    output predecode_t pd1
);

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] FN_JR      = 6'b001000;
    localparam logic [5:0] FN_JALR    = 6'b001001;
    localparam logic [4:0] RT_BLTZ    = 5'b00000;
    localparam logic [4:0] RT_BGEZ    = 5'b00001;
    localparam logic [4:0] RT_BLTZAL  = 5'b10000;
    localparam logic [4:0] RT_BGEZAL  = 5'b10001;
    localparam logic [4:0] REG_RA     = 5'd31;

    function automatic predecode_t classify(word_t instr);
        logic [5:0] op;
        logic [5:0] funct;
        logic [4:0] rs;
        logic [4:0] rt;
        logic       is_branch;
        logic       is_regimm_br;
        op    = instr[31:26];
        rs    = instr[25:21];
        rt    = instr[20:16];
        funct = instr[5:0];
        is_regimm_br = (op == OP_REGIMM) &&
                       (rt == RT_BLTZ || rt == RT_BGEZ ||
                        rt == RT_BLTZAL || rt == RT_BGEZAL);
        is_branch = (op == OP_BEQ) || (op == OP_BNE) || (op == OP_BLEZ) ||
                    (op == OP_BGTZ) || (op == OP_J) || is_regimm_br ||
                    (op == OP_SPECIAL && funct == FN_JALR);
        if (is_branch) begin
            return pd_branch;
        end
        if (op == OP_SPECIAL && funct == FN_JR && rs == REG_RA) begin
            return pd_ret;   // jr ra
        end
        if (op == OP_JAL) begin
            return pd_call;
        end
        return pd_normal;
    endfunction

    assign pd0 = classify(instr0);
    assign pd1 = classify(instr1);

endmodule

// ==== verilog/icache/icache_tag_stage.sv ====
`timescale 1ns/1ps

module icache_tag_stage import icache_pkg::*; #(
    parameter int NUM_SETS = 16
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       req_valid,
    input  addr_t      req_addr,
    input  logic       req_uncached,
    lookup_if.producer lk
);

    localparam int IDX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - IDX_BITS - OFFSET_BITS;

    typedef logic [IDX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    plru_t               plru_q  [NUM_SETS];

    index_t              req_idx;
    tag_t                req_tag;
    logic [NUM_WAYS-1:0] hit_vec;
    logic                req_hit;
    way_t                hit_way;
    way_t                victim;
    logic                take;
    logic                retire;
    logic                allocate;

    // follow the tree bits towards the older side
    function automatic way_t plru_victim(plru_t p);
        if (p[2]) begin
            return p[0] ? 2'd3 : 2'd2;
        end
        return p[1] ? 2'd1 : 2'd0;
    endfunction

    // point the path bits away from the way just used
    function automatic plru_t plru_touch(plru_t p, way_t w);
        plru_t n;
        n = p;
        n[2] = ~w[1];
        if (w[1]) begin
            n[0] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    assign req_idx = req_addr[OFFSET_BITS +: IDX_BITS];
    assign req_tag = req_addr[31 -: TAG_BITS];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[req_idx][w] && (tag_q[req_idx][w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign req_hit  = |hit_vec;
    assign victim   = plru_victim(plru_q[req_idx]);
    assign take     = req_valid && !lk.valid;   // stage one free
    assign retire   = lk.valid && lk.done;
    assign allocate = retire && !lk.uncached && !lk.hit;

    always_ff @(posedge clk) begin
        if (resetn) begin
            lk.valid <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (retire) begin
                lk.valid <= 1'b0;
            end else if (take) begin
                lk.valid <= 1'b1;
            end
            if (retire && !lk.uncached) begin
                plru_q[lk.index] <= plru_touch(plru_q[lk.index], lk.way);
            end
            if (allocate) begin
                valid_q[lk.index][lk.way] <= 1'b1;
            end
        end
    end

    // lookup payload and tag array
    always_ff @(posedge clk) begin
        if (take) begin
            lk.addr     <= req_addr;
            lk.uncached <= req_uncached;
            lk.hit      <= req_hit;
            lk.way      <= req_hit ? hit_way : victim;
        end
        if (allocate) begin
            tag_q[lk.index][lk.way] <= lk.addr[31 -: TAG_BITS];   // refill done
        end
    end

endmodule

// ==== verilog/icache/icache_data_stage.sv ====
`timescale 1ns/1ps

module icache_data_stage import icache_pkg::*; #(
    parameter int NUM_SETS = 16
) (
    input  logic       clk,
    input  logic       resetn,
    lookup_if.consumer lk,
    mem_bus_if.master  mem,
    output logic       resp_valid,
    output word_t      resp_word0,
    output word_t      resp_word1
);

    localparam int IDX_BITS  = $clog2(NUM_SETS);
    localparam int SLOT_BITS = IDX_BITS + $bits(way_t);
    localparam int SLOTS     = NUM_SETS * NUM_WAYS;

    typedef word_t [LINE_WORDS-1:0] line_t;

    line_t data_mem [SLOTS];
    line_t rd_line;     // synchronous array read
    line_t line_buf;    // burst collection
    line_t fill_line;
    line_t src_line;

    line_state_t state;
    line_state_t state_nxt;

    logic [SLOT_BITS-1:0] slot;
    word_sel_t            beat_cnt;
    word_sel_t            fill_sel;
    word_sel_t            word_off;
    logic                 beat;
    logic                 beat_last;

    assign slot     = {lk.index, lk.way};
    assign word_off = lk.addr[OFFSET_BITS-1:2];

    // bus master, request fields are stable for the whole burst
    assign mem.valid = (state == st_refill) || (state == st_uncached);
    assign mem.len   = (state == st_refill) ? LEN_FOUR : LEN_TWO;
    assign mem.addr  = (state == st_refill) ?
                       {lk.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}} :
                       {lk.addr[31:3], 3'b000};

    assign beat      = mem.valid && mem.ready;
    assign beat_last = beat && mem.last;
    assign fill_sel  = mem.addr[OFFSET_BITS-1:2] + beat_cnt;   // uncached starts mid line

    always_comb begin
        fill_line           = line_buf;
        fill_line[fill_sel] = mem.data;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (lk.valid) begin
                    if (lk.uncached) begin
                        state_nxt = st_uncached;
                    end else if (lk.hit) begin
                        state_nxt = st_lookup;
                    end else begin
                        state_nxt = st_refill;
                    end
                end
            end
            st_refill, st_uncached: begin
                if (beat_last) begin
                    state_nxt = st_respond;
                end
            end
            st_lookup, st_respond: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= st_idle;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (beat) begin
                beat_cnt <= mem.last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // line storage
    always_ff @(posedge clk) begin
        if (beat) begin
            line_buf <= fill_line;
        end
        if (state == st_refill && beat_last) begin
            data_mem[slot] <= fill_line;   // written with the last beat
        end
        if (state == st_idle && lk.valid) begin
            rd_line <= data_mem[slot];
        end
    end

    assign resp_valid = (state == st_lookup) || (state == st_respond);
    assign lk.done    = resp_valid;

    assign src_line   = (state == st_lookup) ? rd_line : line_buf;
    assign resp_word0 = src_line[word_off];
    assign resp_word1 = src_line[word_off + 1'b1];

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int NUM_SETS = 16
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       ireq_valid,
    input  addr_t      ireq_addr,
    input  logic       ireq_uncached,
    output logic       iresp_data_ok,
    output word_t      iresp_data0,
    output word_t      iresp_data1,
    output predecode_t iresp_pd0,
    output predecode_t iresp_pd1,
    output logic       mem_valid,
    output addr_t      mem_addr,
    output beat_len_t  mem_len,
    input  logic       mem_ready,
    input  word_t      mem_data,
    input  logic       mem_last
);

    lookup_if #(.NUM_SETS(NUM_SETS)) lk ();
    mem_bus_if mem_bus ();

    // memory side of the bus onto plain ports
    assign mem_valid     = mem_bus.valid;
    assign mem_addr      = mem_bus.addr;
    assign mem_len       = mem_bus.len;
    assign mem_bus.ready = mem_ready;
    assign mem_bus.data  = mem_data;
    assign mem_bus.last  = mem_last;

    icache_tag_stage #(.NUM_SETS(NUM_SETS)) icache_tag_stage_inst (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (ireq_valid),
        .req_addr     (ireq_addr),
        .req_uncached (ireq_uncached),
        .lk           (lk.producer)
    );

    icache_data_stage #(.NUM_SETS(NUM_SETS)) icache_data_stage_inst (
        .clk        (clk),
        .resetn     (resetn),
        .lk         (lk.consumer),
        .mem        (mem_bus.master),
        .resp_valid (iresp_data_ok),
        .resp_word0 (iresp_data0),
        .resp_word1 (iresp_data1)
    );

    fetch_predecode fetch_predecode_inst (
        .instr0 (iresp_data0),
        .instr1 (iresp_data1),
        .pd0    (iresp_pd0),
        .pd1    (iresp_pd1)
    );

endmodule

// ==== dv/tb_mem_responder.sv ====
`timescale 1ns/1ps

module tb_mem_responder import icache_pkg::*; #(
    parameter logic [31:0] SEED = 32'd87
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      mem_valid,
    input  addr_t     mem_addr,
    input  beat_len_t mem_len,
    output logic      mem_ready,
    output word_t     mem_data,
    output logic      mem_last
);

    logic [31:0] rng = SEED;
    int          beat_idx;
    int          gap;

    function automatic logic [31:0] next_rand(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fixed function of the word address, some words are control flow
    function automatic word_t word_at(addr_t a);
        logic [31:0] h;
        h = a[31:2] * 32'h9e37_79b1;
        case (h[31:29])
            3'd0: return {6'b000100, h[25:0]};                      // beq
            3'd1: return {6'b000011, h[25:0]};                      // jal
            3'd2: return 32'h03e0_0008;                             // jr ra
            3'd3: return {6'b000001, h[25:21], 5'b10001, h[15:0]};  // bgezal
            default: return h;
        endcase
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_data  = '0;
        mem_last  = 1'b0;
        beat_idx  = 0;
        gap       = 0;
    end

    always @(negedge clk) begin
        if (resetn) begin
            mem_ready = 1'b0;
            mem_last  = 1'b0;
            beat_idx  = 0;
            gap       = 0;
        end else begin
            if (mem_ready) begin   // beat taken on the last rising edge
                beat_idx = mem_last ? 0 : beat_idx + 1;
                rng = next_rand(rng);
                gap = rng % 4;
            end
            mem_ready = 1'b0;
            mem_last  = 1'b0;
            if (mem_valid) begin
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    mem_ready = 1'b1;
                    mem_data  = word_at(mem_addr + 4 * beat_idx);
                    mem_last  = (beat_idx == mem_len);
                end
            end
        end
    end

endmodule

// ==== dv/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

    localparam int NUM_SETS    = 16;
    localparam int IDX_BITS    = $clog2(NUM_SETS);
    localparam int TAG_BITS    = 32 - IDX_BITS - OFFSET_BITS;
    localparam int NUM_FETCHES = 1500;
    localparam int MAX_CYCLES  = NUM_FETCHES * 40;

    logic       clk = 1'b0;
    logic       resetn;
    logic       ireq_valid;
    addr_t      ireq_addr;
    logic       ireq_uncached;
    logic       iresp_data_ok;
    word_t      iresp_data0;
    word_t      iresp_data1;
    predecode_t iresp_pd0;
    predecode_t iresp_pd1;
    logic       mem_valid;
    addr_t      mem_addr;
    beat_len_t  mem_len;
    logic       mem_ready;
    word_t      mem_data;
    logic       mem_last;

    logic [31:0]         rng;
    int                  cycle_count = 0;
    logic [TAG_BITS-1:0] m_tag   [NUM_SETS][NUM_WAYS];   // reference cache state
    logic                m_valid [NUM_SETS][NUM_WAYS];
    plru_t               m_plru  [NUM_SETS];

    icache_top #(.NUM_SETS(NUM_SETS)) icache_top_inst (.*);

    tb_mem_responder #(.SEED(32'd87)) mem_responder_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("TIMEOUT: the DUT hung and the run passed %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // same address to data rule as the memory model
    function automatic word_t mem_image(addr_t a);
        logic [31:0] h;
        h = a[31:2] * 32'h9e37_79b1;
        case (h[31:29])
            3'd0: return {6'b000100, h[25:0]};
            3'd1: return {6'b000011, h[25:0]};
            3'd2: return 32'h03e0_0008;
            3'd3: return {6'b000001, h[25:21], 5'b10001, h[15:0]};
            default: return h;
        endcase
    endfunction

    function automatic predecode_t expected_class(word_t i);
        case (i[31:26])
            6'd2, 6'd4, 6'd5, 6'd6, 6'd7: return pd_branch;   // j and compare branches
            6'd1: return (i[19:17] == 3'b000) ? pd_branch : pd_normal;
            6'd3: return pd_call;
            6'd0: begin
                if (i[5:0] == 6'd9)
                    return pd_branch;   // jalr
                if (i[5:0] == 6'd8 && i[25:21] == 5'd31)
                    return pd_ret;
                return pd_normal;
            end
            default: return pd_normal;
        endcase
    endfunction

    // root bit set sends the victim to ways 2 and 3
    function automatic way_t lru_way(plru_t p);
        return p[2] ? {1'b1, p[0]} : {1'b0, p[1]};
    endfunction

    function automatic plru_t touched(plru_t p, way_t w);
        plru_t n;
        case (w)
            2'd0: n = {1'b1, 1'b1, p[0]};
            2'd1: n = {1'b1, 1'b0, p[0]};
            2'd2: n = {1'b0, p[1], 1'b1};
            default: n = {1'b0, p[1], 1'b0};
        endcase
        return n;
    endfunction

    task automatic run_fetch(addr_t addr, logic unc);
        int                  cycles;
        int                  bursts;
        int                  first_valid;
        int                  last_cyc;
        int                  idx;
        logic                hit;
        way_t                way;
        logic [TAG_BITS-1:0] tag;
        idx = addr[OFFSET_BITS +: IDX_BITS];
        tag = addr[31 -: TAG_BITS];
        hit = 1'b0;
        way = lru_way(m_plru[idx]);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        ireq_valid    = 1'b1;
        ireq_addr     = addr;
        ireq_uncached = unc;
        cycles = 0;
        bursts = 0;
        first_valid = 0;
        last_cyc = -1;
        do begin
            @(posedge clk);
            cycles++;
            if (mem_valid) begin
                if (first_valid == 0)
                    first_valid = cycles;
                compare("mem_addr", mem_addr, unc ? (addr & ~32'h7) : (addr & ~32'hf));
                compare("mem_len", mem_len, unc ? 32'd1 : 32'd3);
                if (mem_ready && mem_last) begin
                    bursts++;
                    last_cyc = cycles;
                end
            end
        end while (!iresp_data_ok);
        if (hit && !unc) begin
            compare("mem_valid before hit", first_valid, 0);
            compare("hit latency", cycles - 1, 2);   // counted from the taking edge
        end else begin
            compare("burst count", bursts, 1);
            compare("mem_valid start", first_valid, 3);
            compare("iresp_data_ok after last", cycles, last_cyc + 1);
        end
        compare("iresp_data0", iresp_data0, mem_image(addr));
        compare("iresp_data1", iresp_data1, mem_image(addr + 4));
        compare("iresp_pd0", iresp_pd0, expected_class(mem_image(addr)));
        compare("iresp_pd1", iresp_pd1, expected_class(mem_image(addr + 4)));
        if (!unc) begin
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way]   = tag;
            m_plru[idx]       = touched(m_plru[idx], way);
        end
    endtask

    initial begin
        addr_t               addr;
        logic [TAG_BITS-1:0] tag;
        rng           = 32'd87;
        resetn        = 1'b1;
        ireq_valid    = 1'b0;
        ireq_addr     = '0;
        ireq_uncached = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        compare("mem_valid", mem_valid, 0);
        compare("iresp_data_ok", iresp_data_ok, 0);
        for (int n = 0; n < NUM_FETCHES; n++) begin
            rng  = xorshift32(rng);
            tag  = TAG_BITS'(24'h01a000 + 24'(rng % 6) * 24'h000105);   // six tags over four ways
            addr = {tag, rng[9:8], 2'b01, rng[11], 3'b000};
            if (rng[16]) begin
                ireq_valid = 1'b0;
                @(negedge clk);
            end
            run_fetch(addr, rng[14:12] == 3'd0);
            @(negedge clk);
        end
        ireq_valid = 1'b0;
        repeat (4) @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== tb.f ====
common/icache_pkg.sv
common/mem_bus_if.sv
common/lookup_if.sv
verilog/icache/fetch_predecode.sv
verilog/icache/icache_tag_stage.sv
verilog/icache/icache_data_stage.sv
verilog/icache_top.sv
dv/tb_mem_responder.sv
dv/tb_icache.sv
